// File: design/rv_pkg.sv
package rv_pkg;

    localparam int NUM_REGS = 32;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Compare ops return 0 or 1 in bit 0
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_EQ,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_SOURCE_PC_PLUS_FOUR,
        PC_SOURCE_JAL,
        PC_SOURCE_B_OFFSET
    } pc_source_e;

    // Same encoding as funct3 bits 1:0 of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS_FOUR
    } wb_sel_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        alu_src_imm;   // Operand B from immediate
        logic        reg_write;
        wb_sel_e     wb_sel;
        logic        mem_write;
        mem_size_e   mem_size;
        logic        load_unsigned;
        logic        branch;
        logic        jal;
        logic [2:0]  funct3;
        logic [31:0] imm;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] wr_data;
        logic [2:0]  length;     // Store funct3
        logic        wr_enable;
    } bus_req_t;

endpackage

// File: design/program_counter.sv
`timescale 1ns/1ns

module program_counter (
    input  logic        clk,
    input  logic        i_reset,
    input  logic [31:0] i_pc_next,
    output logic [31:0] o_pc
);

    // Fetch address restarts at 0
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc <= '0;
        end else begin
            o_pc <= i_pc_next;
        end
    end

endmodule

// File: design/next_pc_unit.sv
`timescale 1ns/1ns

module next_pc_unit import rv_pkg::*; (
    input  logic [31:0] i_pc,
    input  ctrl_t       i_ctrl,
    input  logic [31:0] i_alu_result,
    output logic [31:0] o_pc_next,
    output logic [31:0] o_pc_plus_four
);

    pc_source_e  pc_source;
    logic [31:0] pc_plus_imm;
    logic        taken;

    assign o_pc_plus_four = i_pc + 32'd4;
    assign pc_plus_imm    = i_pc + i_ctrl.imm;   // J or B immediate from decoder

    // BEQ/BLT/BLTU branch on a set compare bit, BNE/BGE/BGEU on a clear one
    assign taken = i_alu_result[0] == ~i_ctrl.funct3[0];

    always_comb begin
        if (i_ctrl.jal) begin
            pc_source = PC_SOURCE_JAL;
        end else if (i_ctrl.branch && taken) begin
            pc_source = PC_SOURCE_B_OFFSET;
        end else begin
            pc_source = PC_SOURCE_PC_PLUS_FOUR;
        end
    end

    always_comb begin
        case (pc_source)
            PC_SOURCE_JAL, PC_SOURCE_B_OFFSET: o_pc_next = pc_plus_imm;
            default:                           o_pc_next = o_pc_plus_four;
        endcase
    end

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import rv_pkg::*; (
    input  logic [31:0] i_instruction,
    output ctrl_t       o_ctrl,
    output logic [4:0]  o_rs1,
    output logic [4:0]  o_rs2,
    output logic [4:0]  o_rd
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e     arith_op;
    alu_op_e     branch_op;

    assign opcode = opcode_e'(i_instruction[6:0]);
    assign funct3 = i_instruction[14:12];
    assign funct7 = i_instruction[31:25];
    assign o_rs1  = i_instruction[19:15];
    assign o_rs2  = i_instruction[24:20];
    assign o_rd   = i_instruction[11:7];

    assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
    assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
    assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
                    i_instruction[30:25], i_instruction[11:8], 1'b0};
    assign imm_u = {i_instruction[31:12], 12'b0};
    assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
                    i_instruction[20], i_instruction[30:21], 1'b0};

    // OP and OP-IMM share funct3, SUB only exists for register form
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    // Compare kind from funct3 bits 2:1, polarity handled in next_pc_unit
    always_comb begin
        case (funct3[2:1])
            2'b10:   branch_op = ALU_SLT;
            2'b11:   branch_op = ALU_SLTU;
            default: branch_op = ALU_EQ;
        endcase
    end

    always_comb begin
        o_ctrl               = '0;   // No-op unless opcode is known
        o_ctrl.alu_op        = ALU_ADD;
        o_ctrl.wb_sel        = WB_ALU;
        o_ctrl.mem_size      = mem_size_e'(funct3[1:0]);
        o_ctrl.load_unsigned = funct3[2];
        o_ctrl.funct3        = funct3;
        o_ctrl.imm           = imm_i;
        case (opcode)
            OPC_LUI: begin
                o_ctrl.alu_op      = ALU_PASS_B;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.imm         = imm_u;
                o_ctrl.reg_write   = 1'b1;
            end
            OPC_OP_IMM: begin
                o_ctrl.alu_op      = arith_op;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.reg_write   = 1'b1;
            end
            OPC_OP: begin
                o_ctrl.alu_op    = arith_op;
                o_ctrl.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                o_ctrl.alu_src_imm = 1'b1;   // Address = rs1 + imm
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.wb_sel      = WB_MEM;
            end
            OPC_STORE: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.imm         = imm_s;
                o_ctrl.mem_write   = 1'b1;
            end
            OPC_BRANCH: begin
                o_ctrl.alu_op = branch_op;
                o_ctrl.imm    = imm_b;
                o_ctrl.branch = 1'b1;
            end
            OPC_JAL: begin
                o_ctrl.imm       = imm_j;
                o_ctrl.jal       = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_sel    = WB_PC_PLUS_FOUR;   // Link address
            end
            default: ;
        endcase
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ns

module register_file import rv_pkg::*; (
    input  logic        clk,
    input  logic [4:0]  i_rs1,
    input  logic [4:0]  i_rs2,
    input  logic [4:0]  i_rd,
    input  logic        i_write,
    input  logic [31:0] i_wr_data,
    output logic [31:0] o_rs1_data,
    output logic [31:0] o_rs2_data
);

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (i_write && i_rd != 5'd0) begin
            regs[i_rd] <= i_wr_data;
        end
    end

    // x0 reads as zero, its entry is never written
    assign o_rs1_data = (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];

endmodule

// File: design/alu.sv
`timescale 1ns/1ns

module alu import rv_pkg::*; (
    input  alu_op_e     i_op,
    input  logic [31:0] i_a,
    input  logic [31:0] i_b,
    output logic [31:0] o_result
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_SRA:    o_result = $signed(i_a) >>> shamt;
            ALU_SLT:    o_result = {31'd0, $signed(i_a) < $signed(i_b)};
            ALU_SLTU:   o_result = {31'd0, i_a < i_b};
            ALU_EQ:     o_result = {31'd0, i_a == i_b};   // Branch compare
            ALU_PASS_B: o_result = i_b;                    // LUI
            default:    o_result = 32'd0;
        endcase
    end

endmodule

// File: design/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit import rv_pkg::*; (
    input  logic        i_reset,
    input  ctrl_t       i_ctrl,
    input  logic [31:0] i_address,
    input  logic [31:0] i_store_data,
    input  logic [31:0] i_bus_read_data,
    output bus_req_t    o_bus_req,
    output logic [31:0] o_load_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // Store data copied to every lane so memory picks by address
    always_comb begin
        o_bus_req.address   = i_address;
        o_bus_req.length    = {1'b0, i_ctrl.mem_size};
        o_bus_req.wr_enable = i_ctrl.mem_write & ~i_reset;   // Quiet bus in reset
        case (i_ctrl.mem_size)
            BYTE:    o_bus_req.wr_data = {4{i_store_data[7:0]}};
            HALF:    o_bus_req.wr_data = {2{i_store_data[15:0]}};
            default: o_bus_req.wr_data = i_store_data;
        endcase
    end

    // Lane select from address low bits
    assign load_byte = i_bus_read_data[{i_address[1:0], 3'b000} +: 8];
    assign load_half = i_bus_read_data[{i_address[1], 4'b0000} +: 16];

    always_comb begin
        case (i_ctrl.mem_size)
            BYTE: begin
                o_load_data = i_ctrl.load_unsigned ? {24'd0, load_byte}
                                                   : {{24{load_byte[7]}}, load_byte};
            end
            HALF: begin
                o_load_data = i_ctrl.load_unsigned ? {16'd0, load_half}
                                                   : {{16{load_half[15]}}, load_half};
            end
            default: o_load_data = i_bus_read_data;
        endcase
    end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
    input  logic        clk,
    input  logic        i_reset,
    input  logic [31:0] i_bus_read_data,
    input  logic [31:0] i_bus_rom_read_data,
    output logic [2:0]  o_bus_write_length,
    output logic        o_bus_wr_enable,
    output logic [31:0] o_bus_address,
    output logic [31:0] o_bus_wr_data,
    output logic [31:0] o_bus_rom_address
);

    ctrl_t       ctrl;
    bus_req_t    bus_req;
    logic [31:0] pc, pc_next, pc_plus_four;
    logic [31:0] instruction;
    logic [4:0]  rs1, rs2, rd;
    logic [31:0] rs1_data, rs2_data;
    logic [31:0] alu_b, alu_result;
    logic [31:0] load_data, wb_data;

    assign instruction       = i_bus_rom_read_data;
    assign o_bus_rom_address = {2'b00, pc[31:2]};   // ROM is word indexed

    program_counter u_pc (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_pc_next (pc_next),
        .o_pc      (pc)
    );

    next_pc_unit u_next_pc (
        .i_pc           (pc),
        .i_ctrl         (ctrl),
        .i_alu_result   (alu_result),
        .o_pc_next      (pc_next),
        .o_pc_plus_four (pc_plus_four)
    );

    instr_decoder u_decoder (
        .i_instruction (instruction),
        .o_ctrl        (ctrl),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .o_rd          (rd)
    );

    register_file u_regs (
        .clk        (clk),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (rd),
        .i_write    (ctrl.reg_write),
        .i_wr_data  (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    assign alu_b = ctrl.alu_src_imm ? ctrl.imm : rs2_data;

    alu u_alu (
        .i_op     (ctrl.alu_op),
        .i_a      (rs1_data),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    load_store_unit u_lsu (
        .i_reset         (i_reset),
        .i_ctrl          (ctrl),
        .i_address       (alu_result),
        .i_store_data    (rs2_data),
        .i_bus_read_data (i_bus_read_data),
        .o_bus_req       (bus_req),
        .o_load_data     (load_data)
    );

    // Write-back source
    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:          wb_data = load_data;
            WB_PC_PLUS_FOUR: wb_data = pc_plus_four;
            default:         wb_data = alu_result;
        endcase
    end

    assign o_bus_address      = bus_req.address;
    assign o_bus_wr_data      = bus_req.wr_data;
    assign o_bus_write_length = bus_req.length;
    assign o_bus_wr_enable    = bus_req.wr_enable;

endmodule

// File: bench/tb_memory.sv
`timescale 1ns/1ns

module tb_memory import rv_pkg::*; #(
    parameter int ROM_WORDS = 128
) (
    input  logic        clk,
    input  logic [31:0] i_rom_program [ROM_WORDS],
    input  logic [31:0] i_rom_address,
    output logic [31:0] o_rom_data,
    input  logic [31:0] i_address,
    input  logic [31:0] i_wr_data,
    input  logic [2:0]  i_length,
    input  logic        i_wr_enable,
    output logic [31:0] o_read_data
);

    localparam int ROM_AW = $clog2(ROM_WORDS);

    logic [31:0] ram [64];
    logic [3:0]  byte_en;

    // Every word starts distinct so stale lanes show up in loads
    initial begin
        for (int i = 0; i < 64; i++) begin
            ram[i] = {16'hDA7A, 10'd0, 6'(i)};
        end
    end

    assign o_rom_data  = i_rom_program[i_rom_address[ROM_AW-1:0]];   // Word indexed
    assign o_read_data = ram[i_address[7:2]];

    // Lanes picked by size and address low bits
    always_comb begin
        case (i_length[1:0])
            2'b00:   byte_en = 4'b0001 << i_address[1:0];
            2'b01:   byte_en = 4'b0011 << {i_address[1], 1'b0};
            default: byte_en = 4'b1111;
        endcase
    end

    always @(posedge clk) begin
        if (i_wr_enable) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    ram[i_address[7:2]][b*8 +: 8] <= i_wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: bench/tb_core.sv
`timescale 1ns/1ns

module tb_core import rv_pkg::*; ();

    localparam int          ROM_WORDS   = 128;
    localparam logic [31:0] POISON_ADDR = 32'd252;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;   // Already in its byte lane
        mem_size_e   size;
    } store_t;

    logic        clk;
    logic        reset;
    logic [31:0] bus_read_data;
    logic [31:0] rom_read_data;
    logic [2:0]  bus_write_length;
    logic        bus_wr_enable;
    logic [31:0] bus_address;
    logic [31:0] bus_wr_data;
    logic [31:0] rom_address;
    logic [31:0] rom_words [ROM_WORDS];
    logic [31:0] prog [$];
    string       exp_names [$];
    store_t      exp_stores [$];
    int          timeout_limit = 0;
    int          cycle_count = 0;

    rv_core DUT (
        .clk                 (clk),
        .i_reset             (reset),
        .i_bus_read_data     (bus_read_data),
        .i_bus_rom_read_data (rom_read_data),
        .o_bus_write_length  (bus_write_length),
        .o_bus_wr_enable     (bus_wr_enable),
        .o_bus_address       (bus_address),
        .o_bus_wr_data       (bus_wr_data),
        .o_bus_rom_address   (rom_address)
    );

    tb_memory #(.ROM_WORDS(ROM_WORDS)) u_memory (
        .clk           (clk),
        .i_rom_program (rom_words),
        .i_rom_address (rom_address),
        .o_rom_data    (rom_read_data),
        .i_address     (bus_address),
        .i_wr_data     (bus_wr_data),
        .i_length      (bus_write_length),
        .i_wr_enable   (bus_wr_enable),
        .o_read_data   (bus_read_data)
    );

    always #2 clk = ~clk;

    // RV32I instruction formats
    function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_op(input int f3, input int rd, input int rs1,
                                           input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] load_op(input int f3, input int rd, input int rs1,
                                            input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] store_op(input int f3, input int rs2, input int rs1,
                                             input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_op(input int f3, input int rs1, input int rs2,
                                              input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] upper_op(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] jump_op(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] lane_mask(input logic [31:0] address, input mem_size_e size);
        case (size)
            BYTE:    return 32'h0000_00FF << {address[1:0], 3'b000};
            HALF:    return 32'h0000_FFFF << {address[1], 4'b0000};
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compare_size(input string name, input mem_size_e expected,
                                input mem_size_e actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %s, actual %s", name, expected.name(),
                                actual.name()));
        end
    endtask

    task automatic add_store(input string name, input logic [31:0] address,
                             input logic [31:0] data, input mem_size_e size);
        exp_names.push_back(name);
        exp_stores.push_back('{address, data, size});
    endtask

    // Results land at 0x00 upward with x1 = 0x123, x3 = -16, x4 = 5 and x9 as poison
    task automatic assemble_program();
        // Store at PC 0 stays decoded through all of reset
        prog.push_back(store_op(2, 0, 0, 104));      // sw   x0, 104(x0)
        add_store("reset_pc_store", 104, 'h0000_0000, WORD);
        prog.push_back(imm_op(0, 1, 0, 'h123));      // addi x1, x0, 0x123
        prog.push_back(store_op(2, 1, 0, 0));        // sw   x1, 0(x0)
        add_store("addi", 0, 'h0000_0123, WORD);
        prog.push_back(upper_op(2, 'h80001));        // lui  x2, 0x80001
        prog.push_back(store_op(2, 2, 0, 4));        // sw   x2, 4(x0)
        add_store("lui", 4, 'h8000_1000, WORD);
        prog.push_back(imm_op(0, 3, 0, -16));        // addi x3, x0, -16
        prog.push_back(imm_op(0, 4, 0, 5));          // addi x4, x0, 5
        prog.push_back(imm_op(0, 9, 0, 'h666));      // addi x9, x0, 0x666
        prog.push_back(reg_op(0, 0, 5, 1, 4));       // add  x5, x1, x4
        prog.push_back(store_op(2, 5, 0, 8));
        add_store("add", 8, 'h0000_0128, WORD);
        prog.push_back(reg_op('h20, 0, 5, 4, 1));    // sub  x5, x4, x1
        prog.push_back(store_op(2, 5, 0, 12));
        add_store("sub", 12, 'hFFFF_FEE2, WORD);
        prog.push_back(reg_op(0, 7, 5, 1, 3));       // and  x5, x1, x3
        prog.push_back(store_op(2, 5, 0, 16));
        add_store("and", 16, 'h0000_0120, WORD);
        prog.push_back(reg_op(0, 6, 5, 1, 3));       // or   x5, x1, x3
        prog.push_back(store_op(2, 5, 0, 20));
        add_store("or", 20, 'hFFFF_FFF3, WORD);
        prog.push_back(reg_op(0, 4, 5, 1, 3));       // xor  x5, x1, x3
        prog.push_back(store_op(2, 5, 0, 24));
        add_store("xor", 24, 'hFFFF_FED3, WORD);
        prog.push_back(reg_op(0, 1, 5, 1, 4));       // sll  x5, x1, x4
        prog.push_back(store_op(2, 5, 0, 28));
        add_store("sll", 28, 'h0000_2460, WORD);
        prog.push_back(reg_op(0, 5, 5, 3, 4));       // srl  x5, x3, x4
        prog.push_back(store_op(2, 5, 0, 32));
        add_store("srl", 32, 'h07FF_FFFF, WORD);
        prog.push_back(reg_op('h20, 5, 5, 3, 4));    // sra  x5, x3, x4
        prog.push_back(store_op(2, 5, 0, 36));
        add_store("sra", 36, 'hFFFF_FFFF, WORD);
        prog.push_back(reg_op(0, 2, 5, 4, 3));       // slt  x5, x4, x3
        prog.push_back(store_op(2, 5, 0, 40));
        add_store("slt", 40, 'h0000_0000, WORD);
        prog.push_back(reg_op(0, 3, 5, 4, 3));       // sltu x5, x4, x3
        prog.push_back(store_op(2, 5, 0, 44));
        add_store("sltu", 44, 'h0000_0001, WORD);

        // Word at 48 ends up as 0xFFF09A78
        prog.push_back(upper_op(6, 'h12345));        // lui  x6, 0x12345
        prog.push_back(imm_op(0, 6, 6, 'h678));      // addi x6, x6, 0x678
        prog.push_back(store_op(2, 6, 0, 48));       // sw   x6, 48(x0)
        add_store("sw_word", 48, 'h1234_5678, WORD);
        prog.push_back(imm_op(0, 7, 0, -102));       // addi x7, x0, -102
        prog.push_back(store_op(0, 7, 0, 49));       // sb   x7, 49(x0)
        add_store("sb_lane", 49, 'h0000_9A00, BYTE);
        prog.push_back(store_op(1, 3, 0, 50));       // sh   x3, 50(x0)
        add_store("sh_lane", 50, 'hFFF0_0000, HALF);
        prog.push_back(load_op(0, 8, 0, 49));        // lb   x8, 49(x0)
        prog.push_back(store_op(2, 8, 0, 52));
        add_store("lb", 52, 'hFFFF_FF9A, WORD);
        prog.push_back(load_op(4, 8, 0, 49));        // lbu  x8, 49(x0)
        prog.push_back(store_op(2, 8, 0, 56));
        add_store("lbu", 56, 'h0000_009A, WORD);
        prog.push_back(load_op(1, 8, 0, 50));        // lh   x8, 50(x0)
        prog.push_back(store_op(2, 8, 0, 60));
        add_store("lh", 60, 'hFFFF_FFF0, WORD);
        prog.push_back(load_op(5, 8, 0, 50));        // lhu  x8, 50(x0)
        prog.push_back(store_op(2, 8, 0, 64));
        add_store("lhu", 64, 'h0000_FFF0, WORD);
        prog.push_back(load_op(2, 8, 0, 48));        // lw   x8, 48(x0)
        prog.push_back(store_op(2, 8, 0, 68));
        add_store("lw", 68, 'hFFF0_9A78, WORD);

        // Taken branches jump over a poison store and not taken ones fall into a marker store
        prog.push_back(branch_op(0, 1, 1, 8));       // beq  x1, x1, +8
        prog.push_back(store_op(2, 9, 0, 252));      // sw   x9, 252(x0) poison
        prog.push_back(branch_op(0, 1, 4, 8));       // beq  x1, x4, +8
        prog.push_back(store_op(2, 1, 0, 72));
        add_store("beq_not_taken", 72, 'h0000_0123, WORD);
        prog.push_back(branch_op(1, 1, 4, 8));       // bne  x1, x4, +8
        prog.push_back(store_op(2, 9, 0, 252));
        prog.push_back(branch_op(1, 1, 1, 8));       // bne  x1, x1, +8
        prog.push_back(store_op(2, 1, 0, 76));
        add_store("bne_not_taken", 76, 'h0000_0123, WORD);
        prog.push_back(branch_op(4, 3, 4, 8));       // blt  x3, x4, +8
        prog.push_back(store_op(2, 9, 0, 252));
        prog.push_back(branch_op(4, 4, 3, 8));       // blt  x4, x3, +8
        prog.push_back(store_op(2, 1, 0, 80));
        add_store("blt_not_taken", 80, 'h0000_0123, WORD);
        prog.push_back(branch_op(5, 4, 3, 8));       // bge  x4, x3, +8
        prog.push_back(store_op(2, 9, 0, 252));
        prog.push_back(branch_op(5, 3, 4, 8));       // bge  x3, x4, +8
        prog.push_back(store_op(2, 1, 0, 84));
        add_store("bge_not_taken", 84, 'h0000_0123, WORD);
        prog.push_back(branch_op(6, 4, 3, 8));       // bltu x4, x3, +8
        prog.push_back(store_op(2, 9, 0, 252));
        prog.push_back(branch_op(6, 3, 4, 8));       // bltu x3, x4, +8
        prog.push_back(store_op(2, 1, 0, 88));
        add_store("bltu_not_taken", 88, 'h0000_0123, WORD);
        prog.push_back(branch_op(7, 3, 4, 8));       // bgeu x3, x4, +8
        prog.push_back(store_op(2, 9, 0, 252));
        prog.push_back(branch_op(7, 4, 3, 8));       // bgeu x4, x3, +8
        prog.push_back(store_op(2, 1, 0, 92));
        add_store("bgeu_not_taken", 92, 'h0000_0123, WORD);

        prog.push_back(jump_op(10, 8));              // jal  x10, +8
        add_store("jal_link", 96, 4 * prog.size(), WORD);   // Address after the JAL
        prog.push_back(store_op(2, 9, 0, 252));
        prog.push_back(store_op(2, 10, 0, 96));      // sw   x10, 96(x0)
        prog.push_back(imm_op(0, 0, 0, 'h55));       // addi x0, x0, 0x55
        prog.push_back(store_op(2, 0, 0, 100));      // sw   x0, 100(x0)
        add_store("x0_write", 100, 'h0000_0000, WORD);
        prog.push_back(jump_op(0, 0));               // jal  x0, 0
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            abort_run("timeout: stores missing");
        end
    end

    initial begin
        int          store_idx;
        int          run_cycles;
        store_t      entry;
        logic [31:0] mask;

        clk   = 1'b0;
        reset = 1'b1;
        assemble_program();
        timeout_limit = 16 + 4 * prog.size();
        foreach (rom_words[i]) begin
            rom_words[i] = (i < prog.size()) ? prog[i] : 32'd0;
        end

        // PC only settles at the first edge of the sync reset
        repeat (15) begin
            @(posedge clk);
            @(negedge clk);
            check_word("reset_rom_address", 32'd0, rom_address);
            check_word("reset_wr_enable", 32'd0, {31'd0, bus_wr_enable});
        end
        @(posedge clk);
        #1 reset = 1'b0;

        store_idx  = 0;
        run_cycles = 0;
        while (store_idx < exp_stores.size() || rom_address != prog.size() - 1) begin
            @(negedge clk);
            if (run_cycles < 3) begin
                check_word("release_rom_address", run_cycles, rom_address);
            end
            if (bus_wr_enable) begin
                if (bus_address == POISON_ADDR) begin
                    abort_run("poison store reached the bus, a skipped path was executed");
                end else if (store_idx >= exp_stores.size()) begin
                    abort_run("unexpected extra store before the final self-loop");
                end else begin
                    entry = exp_stores[store_idx];
                    mask  = lane_mask(entry.address, entry.size);
                    check_word({exp_names[store_idx], " address"}, entry.address, bus_address);
                    compare_size({exp_names[store_idx], " size"}, entry.size,
                                 mem_size_e'(bus_write_length[1:0]));
                    check_word({exp_names[store_idx], " length msb"}, 32'd0,
                               {31'd0, bus_write_length[2]});
                    check_word({exp_names[store_idx], " data"}, entry.data, bus_wr_data & mask);
                    store_idx++;
                end
            end
            run_cycles++;
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sim.f
design/rv_pkg.sv
design/program_counter.sv
design/next_pc_unit.sv
design/instr_decoder.sv
design/register_file.sv
design/alu.sv
design/load_store_unit.sv
design/rv_core.sv
bench/tb_memory.sv
bench/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_core
FILELIST  := sim.f
FLAGS     := --binary --timescale 1ns/1ns -j 0

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: run clean

# Exit status of the binary is the pass or fail result
run: $(BIN)
	./$(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
